//--- sources.f
+incdir+src
src/mont_pkg.sv
src/mont_ctrl.sv
src/mont_operand_sel.sv
src/mont_limb_adder.sv
src/mont_accum.sv
src/mont_top.sv
tb/tb_clkgen.sv
tb/tb_mont_checker.sv
tb/tb_mont_top.sv

//--- Bender.yml
package:
  name: mont_mult

export_include_dirs:
  - src

sources:
  - src/mont_pkg.sv
  - src/mont_ctrl.sv
  - src/mont_operand_sel.sv
  - src/mont_limb_adder.sv
  - src/mont_accum.sv
  - src/mont_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_mont_checker.sv
      - tb/tb_mont_top.sv

//--- tb/tb_mont_top.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module tb_mont_top;

    localparam int W = `MONT_WIDTH;
    localparam int OP_CYCLES = (2 * `NUM_DIGITS + 4) * (`NUM_LIMBS + 1);
    localparam int NUM_RANDOM = 40;
    // Random, zero A, identity, busy op and window, abort and window and retry
    localparam int NUM_OPS = NUM_RANDOM + 3 + 4 + 2 + 3;
    localparam int CYCLE_LIMIT = NUM_OPS * OP_CYCLES + 2000;

    logic clk;
    logic por_resetn;
    logic abort_n;
    logic resetn;
    logic start;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] m;
    logic [W-1:0] result;
    logic done;
    logic [31:0] rng;
    int cycles = 0;
    int ops_expected = 0;
    int pass_count;
    int fail_count;
    int stray_done;

    assign resetn = por_resetn & abort_n;

    tb_clkgen clkgen_i (
        .clk    (clk),
        .resetn (por_resetn)
    );

    mont_top dut_i (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    tb_mont_checker checker_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .a          (a),
        .b          (b),
        .m          (m),
        .done       (done),
        .result     (result),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .stray_done (stray_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_word(output logic [W-1:0] v);
        v = '0;
        repeat ((W + 31) / 32) begin
            rng = xorshift32(rng);
            v = (v << 32) | W'(rng);
        end
    endtask

    task automatic random_modulus(output logic [W-1:0] v);
        random_word(v);
        v[W-1] = 1'b1;
        v[0] = 1'b1;
    endtask

    task automatic random_below(input logic [W-1:0] mod, output logic [W-1:0] v);
        random_word(v);
        v = v % mod;
    endtask

    // 2^W mod M by doubling
    function automatic logic [W-1:0] pow2w_mod(input logic [W-1:0] mod);
        logic [W:0] r;
        r = 1;
        repeat (W) begin
            r = r << 1;
            if (r >= mod)
                r = r - mod;
        end
        return r[W-1:0];
    endfunction

    task automatic launch(input logic [W-1:0] av, input logic [W-1:0] bv,
                          input logic [W-1:0] mv);
        @(negedge clk);
        a = av;
        b = bv;
        m = mv;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_op(input logic [W-1:0] av, input logic [W-1:0] bv,
                          input logic [W-1:0] mv);
        launch(av, bv, mv);
        ops_expected++;
        while (!done)
            @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no progress after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [W-1:0] rm;
        logic [W-1:0] ra;
        logic [W-1:0] rb;
        int other_errors;
        other_errors = 0;
        rng = 32'hee5d_9521;
        start = 1'b0;
        a = '0;
        b = '0;
        m = '0;
        abort_n = 1'b1;
        @(posedge por_resetn);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_modulus(rm);
            random_below(rm, ra);
            random_below(rm, rb);
            run_op(ra, rb, rm);
        end

        // Zero multiplicand
        for (int i = 0; i < 3; i++) begin
            random_modulus(rm);
            random_below(rm, rb);
            run_op('0, rb, rm);
        end

        // B = R mod M gives back A
        for (int i = 0; i < 4; i++) begin
            random_modulus(rm);
            random_below(rm, ra);
            if (i == 0)
                ra = rm - 1'b1;
            if (i == 1)
                ra = 1;
            run_op(ra, pow2w_mod(rm), rm);
        end

        // Stray start with other operands while busy
        random_modulus(rm);
        random_below(rm, ra);
        random_below(rm, rb);
        launch(ra, rb, rm);
        ops_expected++;
        repeat (OP_CYCLES / 4) @(negedge clk);
        random_word(a);
        random_word(b);
        random_word(m);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        repeat (OP_CYCLES) @(negedge clk);

        // Reset halfway through an operation
        launch(ra, rb, rm);
        repeat (OP_CYCLES / 3) @(negedge clk);
        abort_n = 1'b0;
        repeat (3) @(negedge clk);
        abort_n = 1'b1;
        repeat (OP_CYCLES) @(negedge clk);
        run_op(rb, ra, rm);

        repeat (4) @(negedge clk);
        if (pass_count + fail_count != ops_expected) begin
            $display("Expected %0d results but saw %0d", ops_expected, pass_count + fail_count);
            other_errors++;
        end
        $display("Summary: %0d passed, %0d failed, %0d stray done, %0d other errors",
                 pass_count, fail_count, stray_done, other_errors);
        if (fail_count == 0 && stray_done == 0 && other_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- tb/tb_mont_checker.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module tb_mont_checker (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic [`MONT_WIDTH-1:0] a,
    input  logic [`MONT_WIDTH-1:0] b,
    input  logic [`MONT_WIDTH-1:0] m,
    input  logic                   done,
    input  logic [`MONT_WIDTH-1:0] result,
    output int                     pass_count,
    output int                     fail_count,
    output int                     stray_done
);

    localparam int W = `MONT_WIDTH;

    logic busy;
    logic [W-1:0] cap_a;
    logic [W-1:0] cap_b;
    logic [W-1:0] cap_m;
    int test_num;

    // Bit-serial Montgomery, one bit of A per step, then one subtraction
    function automatic logic [W-1:0] mont_ref(input logic [W-1:0] x, input logic [W-1:0] y,
                                              input logic [W-1:0] mod);
        logic [W+1:0] acc;
        acc = '0;
        for (int i = 0; i < W; i++) begin
            if (x[i])
                acc = acc + y;
            if (acc[0])
                acc = acc + mod;
            acc = acc >> 1;
        end
        if (acc >= mod)
            acc = acc - mod;
        return acc[W-1:0];
    endfunction

    initial begin
        busy = 1'b0;
        test_num = 0;
        pass_count = 0;
        fail_count = 0;
        stray_done = 0;
    end

    always @(posedge clk) begin
        logic [W-1:0] expected;
        if (!resetn) begin
            if (busy)
                $display("test %0d aborted by reset at %0t ns", test_num, $time);
            busy <= 1'b0;
        end else if (busy && done) begin
            expected = mont_ref(cap_a, cap_b, cap_m);
            busy <= 1'b0;
            if (result === expected) begin
                pass_count <= pass_count + 1;
                $display("test %0d passed: result %h", test_num, result);
            end else begin
                fail_count <= fail_count + 1;
                $display("MISMATCH at %0t ns: result expected %h actual %h",
                         $time, expected, result);
                $display("test %0d failed", test_num);
            end
        end else if (done) begin
            stray_done <= stray_done + 1;
            $display("Done pulse at %0t ns without an accepted start", $time);
        end else if (start && !busy) begin
            // DUT is idle, so this start is accepted
            busy <= 1'b1;
            cap_a <= a;
            cap_b <= b;
            cap_m <= m;
            test_num <= test_num + 1;
        end
    end

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD = 8.0,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- src/mont_top.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module mont_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic [`MONT_WIDTH-1:0] a,
    input  logic [`MONT_WIDTH-1:0] b,
    input  logic [`MONT_WIDTH-1:0] m,
    output logic [`MONT_WIDTH-1:0] result,
    output logic                   done
);
    import mont_pkg::*;

    localparam int W = `MONT_WIDTH;
    localparam int AW = `ADDER_WIDTH;
    localparam int LW = `LIMB_WIDTH;
    localparam int NL = `NUM_LIMBS;

    mont_op_e op;
    logic add_start;
    logic subtract;
    logic load_ops;
    logic shift_a;
    logic cap_pre;
    logic acc_clear;
    logic acc_load;
    logic acc_shift;
    logic carry_seed;
    logic [AW-1:0] op_a;
    logic [AW-1:0] op_b;
    logic [AW-1:0] sum;
    logic [AW-1:0] c;
    // Registered carry between limbs, top bit is the adder overflow
    logic [NL:0] carry;

    mont_ctrl ctrl_i (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .c_sign    (c[AW-1]),
        .c_low     (c[1:0]),
        .done      (done),
        .add_start (add_start),
        .subtract  (subtract),
        .load_ops  (load_ops),
        .shift_a   (shift_a),
        .cap_pre   (cap_pre),
        .acc_clear (acc_clear),
        .acc_load  (acc_load),
        .acc_shift (acc_shift),
        .op        (op)
    );

    mont_operand_sel sel_i (
        .clk        (clk),
        .resetn     (resetn),
        .load_ops   (load_ops),
        .shift_a    (shift_a),
        .cap_pre    (cap_pre),
        .add_start  (add_start),
        .subtract   (subtract),
        .a          (a),
        .b          (b),
        .m          (m),
        .op         (op),
        .c          (c),
        .sum        (sum),
        .op_a       (op_a),
        .op_b       (op_b),
        .carry_seed (carry_seed)
    );

    assign carry[0] = carry_seed;

    for (genvar i = 0; i < NL; i++) begin : g_limb
        mont_limb_adder #(
            .LIMB_WIDTH (LW)
        ) limb_i (
            .clk       (clk),
            .resetn    (resetn),
            .start     (add_start),
            .in_a      (op_a[i*LW +: LW]),
            .in_b      (op_b[i*LW +: LW]),
            .carry_in  (carry[i]),
            .sum       (sum[i*LW +: LW]),
            .carry_out (carry[i+1])
        );
    end

    mont_accum accum_i (
        .clk    (clk),
        .resetn (resetn),
        .clear  (acc_clear),
        .load   (acc_load),
        .shift  (acc_shift),
        .sum    (sum),
        .c      (c)
    );

    assign result = c[W-1:0];

endmodule

//--- src/mont_accum.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module mont_accum (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    clear,
    input  logic                    load,
    input  logic                    shift,
    input  logic [`ADDER_WIDTH-1:0] sum,
    output logic [`ADDER_WIDTH-1:0] c
);

    localparam int AW = `ADDER_WIDTH;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            c <= '0;
        end else if (clear) begin
            c <= '0;
        end else if (load) begin
            // Divide by 4 after the quotient step
            c <= shift ? {2'b00, sum[AW-1:2]} : sum;
        end
    end

    // The quotient multiple of M must clear the two low bits
    shift_divisible: assert property (@(posedge clk) disable iff (!resetn)
        (load && shift) |-> sum[1:0] == 2'b00);

endmodule

//--- src/mont_limb_adder.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module mont_limb_adder #(
    parameter int LIMB_WIDTH = `LIMB_WIDTH
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic [LIMB_WIDTH-1:0] in_a,
    input  logic [LIMB_WIDTH-1:0] in_b,
    input  logic                  carry_in,
    output logic [LIMB_WIDTH-1:0] sum,
    output logic                  carry_out
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sum <= '0;
            carry_out <= 1'b0;
        end else if (start) begin
            {carry_out, sum} <= {1'b0, in_a} + {1'b0, in_b}
                                + (LIMB_WIDTH + 1)'(carry_in);
        end else begin
            // Absorb the carry from the limb below, one limb per cycle
            {carry_out, sum} <= {1'b0, sum} + (LIMB_WIDTH + 1)'(carry_in);
        end
    end

endmodule

//--- src/mont_operand_sel.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module mont_operand_sel (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    load_ops,
    input  logic                    shift_a,
    input  logic                    cap_pre,
    input  logic                    add_start,
    input  logic                    subtract,
    input  logic [`MONT_WIDTH-1:0]  a,
    input  logic [`MONT_WIDTH-1:0]  b,
    input  logic [`MONT_WIDTH-1:0]  m,
    input  mont_pkg::mont_op_e      op,
    input  logic [`ADDER_WIDTH-1:0] c,
    input  logic [`ADDER_WIDTH-1:0] sum,
    output logic [`ADDER_WIDTH-1:0] op_a,
    output logic [`ADDER_WIDTH-1:0] op_b,
    output logic                    carry_seed
);
    import mont_pkg::*;

    localparam int W = `MONT_WIDTH;
    localparam int AW = `ADDER_WIDTH;

    logic [W-1:0] a_q;
    logic [W-1:0] b_q;
    logic [W-1:0] m_q;
    logic [W+1:0] b3_q;
    logic [W+1:0] m3_q;
    logic [AW-1:0] b_ext;
    logic [AW-1:0] m_ext;
    logic [AW-1:0] b_mult;
    logic [AW-1:0] m_mult;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
            b_q <= '0;
            m_q <= '0;
            b3_q <= '0;
            m3_q <= '0;
        end else begin
            if (load_ops) begin
                a_q <= a;
                b_q <= b;
                m_q <= m;
            end else if (shift_a) begin
                // Next radix-4 digit of A
                a_q <= {2'b00, a_q[W-1:2]};
            end
            if (cap_pre && op == OP_PRE_B3)
                b3_q <= sum[W+1:0];
            if (cap_pre && op == OP_PRE_M3)
                m3_q <= sum[W+1:0];
        end
    end

    assign b_ext = AW'(b_q);
    assign m_ext = AW'(m_q);

    always_comb begin
        case (a_q[1:0])
            2'd0:    b_mult = '0;
            2'd1:    b_mult = b_ext;
            2'd2:    b_mult = b_ext << 1;
            default: b_mult = AW'(b3_q);
        endcase
    end

    // Quotient digit makes C + q*M divisible by 4, depends on M mod 4
    always_comb begin
        case (c[1:0])
            2'd0:    m_mult = '0;
            2'd1:    m_mult = m_q[1] ? m_ext : AW'(m3_q);
            2'd2:    m_mult = m_ext << 1;
            default: m_mult = m_q[1] ? AW'(m3_q) : m_ext;
        endcase
    end

    always_comb begin
        op_a = c;
        op_b = '0;
        case (op)
            OP_PRE_B3: begin
                op_a = b_ext << 1;
                op_b = b_ext;
            end
            OP_PRE_M3: begin
                op_a = m_ext << 1;
                op_b = m_ext;
            end
            OP_DIGIT_B: op_b = b_mult;
            OP_DIGIT_M: op_b = m_mult;
            // Two's complement subtract, the +1 comes in as carry seed
            OP_SUB_M:   op_b = subtract ? ~m_ext : m_ext;
            default:    op_b = '0;
        endcase
    end

    assign carry_seed = add_start & subtract;

endmodule

//--- src/mont_ctrl.sv
`timescale 1ns/10ps
`include "mont_consts.svh"

module mont_ctrl (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  logic               c_sign,
    input  logic [1:0]         c_low,
    output logic               done,
    output logic               add_start,
    output logic               subtract,
    output logic               load_ops,
    output logic               shift_a,
    output logic               cap_pre,
    output logic               acc_clear,
    output logic               acc_load,
    output logic               acc_shift,
    output mont_pkg::mont_op_e op
);
    import mont_pkg::*;

    localparam int LIMB_CNT_W = $clog2(`NUM_LIMBS + 1);
    localparam int DIGIT_CNT_W = $clog2(`NUM_DIGITS + 1);
    localparam logic [LIMB_CNT_W-1:0] LAST_LIMB_CYCLE = LIMB_CNT_W'(`NUM_LIMBS);
    localparam logic [DIGIT_CNT_W-1:0] LAST_DIGIT = DIGIT_CNT_W'(`NUM_DIGITS - 1);

    mont_state_e state;
    mont_state_e state_next;
    logic [LIMB_CNT_W-1:0] limb_cnt;
    logic [DIGIT_CNT_W-1:0] digit_cnt;
    logic adding;
    logic capture;
    logic skip_restore;

    assign adding = state inside {PRE_B3, PRE_M3, ADD_B, ADD_M, SUB_M, RESTORE_M};
    // Sum is final once the carries have crossed every limb
    assign capture = adding && (limb_cnt == LAST_LIMB_CYCLE);
    // No add-back when the difference is already non-negative
    assign skip_restore = (state == RESTORE_M) && (limb_cnt == '0) && !c_sign;

    assign load_ops = (state == IDLE) && start;
    assign acc_clear = load_ops;
    assign add_start = adding && (limb_cnt == '0) && !skip_restore;
    assign subtract = (state == SUB_M);
    assign cap_pre = capture && (state inside {PRE_B3, PRE_M3});
    assign shift_a = capture && (state == ADD_B);
    assign acc_load = capture && (state inside {ADD_B, ADD_M, SUB_M, RESTORE_M});
    assign acc_shift = capture && (state == ADD_M);

    always_comb begin
        case (state)
            PRE_B3:  op = OP_PRE_B3;
            PRE_M3:  op = OP_PRE_M3;
            ADD_B:   op = OP_DIGIT_B;
            ADD_M:   op = OP_DIGIT_M;
            default: op = OP_SUB_M;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start)
                    state_next = PRE_B3;
            end
            PRE_B3: begin
                if (capture)
                    state_next = PRE_M3;
            end
            PRE_M3: begin
                if (capture)
                    state_next = ADD_B;
            end
            ADD_B: begin
                if (capture)
                    state_next = ADD_M;
            end
            ADD_M: begin
                if (capture)
                    state_next = (digit_cnt == LAST_DIGIT) ? SUB_M : ADD_B;
            end
            SUB_M: begin
                if (capture)
                    state_next = RESTORE_M;
            end
            RESTORE_M: begin
                if (capture || skip_restore)
                    state_next = DONE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
            limb_cnt <= '0;
            digit_cnt <= '0;
            done <= 1'b0;
        end else begin
            state <= state_next;
            // Pulse once the final add-back or its skip has completed
            done <= (state == RESTORE_M) && (capture || skip_restore);
            if (adding && !capture && !skip_restore)
                limb_cnt <= limb_cnt + 1'b1;
            else
                limb_cnt <= '0;
            if (load_ops)
                digit_cnt <= '0;
            else if (capture && state == ADD_M)
                digit_cnt <= digit_cnt + 1'b1;
        end
    end

    // Limb carries must drain before the next addition starts
    add_start_spacing: assert property (@(posedge clk) disable iff (!resetn)
        add_start |=> !add_start [*`NUM_LIMBS]);

    done_in_done_state: assert property (@(posedge clk) disable iff (!resetn)
        done |-> state == DONE);

    // C was emptied at start and precompute never writes it
    c_empty_at_first_digit: assert property (@(posedge clk) disable iff (!resetn)
        (add_start && state == ADD_B && digit_cnt == '0) |-> c_low == 2'b00);

endmodule

//--- src/mont_pkg.sv
package mont_pkg;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        PRE_B3    = 3'd1,
        PRE_M3    = 3'd2,
        ADD_B     = 3'd3,
        ADD_M     = 3'd4,
        SUB_M     = 3'd5,
        RESTORE_M = 3'd6,
        DONE      = 3'd7
    } mont_state_e;

    // Operand selection for the adder
    typedef enum logic [2:0] {
        OP_PRE_B3  = 3'd0,
        OP_PRE_M3  = 3'd1,
        OP_DIGIT_B = 3'd2,
        OP_DIGIT_M = 3'd3,
        // Shared by the subtraction and the restore addition
        OP_SUB_M   = 3'd4
    } mont_op_e;

endpackage

//--- src/mont_consts.svh
`ifndef MONT_CONSTS_SVH
`define MONT_CONSTS_SVH

// Operand width W, the product carries a factor of 2^-W
`define MONT_WIDTH 124

// Four guard bits so that C, 3B and the sign of C - M all fit
`define ADDER_WIDTH (`MONT_WIDTH + 4)

// One registered adder slice
`define LIMB_WIDTH 32

`define NUM_LIMBS (`ADDER_WIDTH / `LIMB_WIDTH)

// Radix-4 loop, two bits of A per iteration
`define NUM_DIGITS (`MONT_WIDTH / 2)

`endif
